// ==== verilog/cart_defs.svh ====
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// CPU side of the cartridge slot
`define CART_ADDR_W       16  // Z80 address bus
`define CART_DATA_W       8   // Z80 data bus

// Memory side
`define CART_MEM_ADDR_W   27  // Flat address into ROM or SRAM storage
`define CART_BANK_W       8   // One 16 KB bank number

// Configuration fields
`define CART_ROM_SIZE_W   25  // ROM size in bytes, up to 32 MB
`define CART_SRAM_SIZE_W  16  // SRAM size in kilobytes

// Independent mapper instances sharing the logic
`define CART_NUM_IDS      2

`endif

// ==== verilog/cart_bus_pkg.sv ====
`include "cart_defs.svh"

package cart_bus_pkg;

    // Plain CPU bus vectors
    typedef logic [`CART_ADDR_W-1:0]     cpu_addr_t;
    typedef logic [`CART_DATA_W-1:0]     cpu_data_t;

    // Address toward the storage behind the mapper
    typedef logic [`CART_MEM_ADDR_W-1:0] mem_addr_t;

    // One CPU memory access, all levels active high
    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t data;  // Write data
        logic      rd;
        logic      wr;
        logic      mreq;  // Memory request qualifier
    } cpu_req_t;

    // Request toward ROM and SRAM
    typedef struct packed {
        logic      ram_cs;   // ROM select
        logic      sram_cs;  // Battery SRAM select
        logic      rnw;      // Low only for an SRAM write
        mem_addr_t addr;     // All ones when idle
    } mem_out_t;

endpackage

// ==== verilog/cart_mapper_pkg.sv ====
`include "cart_defs.svh"

package cart_mapper_pkg;

    typedef logic [`CART_BANK_W-1:0]            bank_t;
    typedef logic [$clog2(`CART_NUM_IDS)-1:0]   mapper_id_t;  // Single bit for two ids

    // Supported mapper flavours
    typedef enum logic [1:0] {
        MAPPER_NONE    = 2'd0,
        MAPPER_ASCII16 = 2'd1,
        MAPPER_RTYPE   = 2'd2
    } mapper_typ_e;

    // Static configuration of the inserted cartridge
    typedef struct packed {
        mapper_typ_e                    typ;
        mapper_id_t                     id;         // Which register set to use
        logic [`CART_ROM_SIZE_W-1:0]    rom_size;   // Bytes
        logic [`CART_SRAM_SIZE_W-1:0]   sram_size;  // Kilobytes, zero means none
    } mapper_cfg_t;

    // Single bank register update
    typedef struct packed {
        logic  valid;  // Update this cycle
        logic  half;   // 0 selects the 4000h window, 1 the 8000h window
        logic  sram;   // Set SRAM enable instead of loading a bank
        bank_t value;  // New bank number when sram is low
    } reg_wr_t;

endpackage

// ==== verilog/cart_map_ctrl.sv ====
`timescale 1ns/1ns

module cart_map_ctrl (
    input  cart_bus_pkg::cpu_req_t    bus_req,
    input  cart_mapper_pkg::mapper_cfg_t cfg,
    output logic                      cs,
    output logic                      rtype,
    output cart_mapper_pkg::reg_wr_t  wr_cmd
);

    logic mapped;       // Access hits 4000h to BFFFh
    logic mapper_en;    // Type is one we serve
    logic sram_exists;
    logic wr_hit;       // Qualified write into the mapper area

    assign mapped    = ^bus_req.addr[15:14];  // Bits differ only in the two middle pages
    assign mapper_en = (cfg.typ == cart_mapper_pkg::MAPPER_ASCII16) |
                       (cfg.typ == cart_mapper_pkg::MAPPER_RTYPE);
    assign rtype     = (cfg.typ == cart_mapper_pkg::MAPPER_RTYPE);
    assign cs        = mapped & mapper_en & bus_req.mreq;

    assign sram_exists = (cfg.sram_size != '0);
    assign wr_hit      = cs & bus_req.wr;

    // Switching window decode
    always_comb begin
        wr_cmd = '0;  // No update by default
        if (wr_hit) begin
            if (rtype) begin
                // R-Type has a single register at 7000h to 7FFFh for the upper window
                if (bus_req.addr[15:12] == 4'b0111) begin
                    wr_cmd.valid = 1'b1;
                    wr_cmd.half  = 1'b1;
                    wr_cmd.sram  = 1'b0;
                    // Bit 4 set limits the bank to the 17h pattern
                    wr_cmd.value = bus_req.data & (bus_req.data[4] ? 8'h17 : 8'h1F);
                end
            end else begin
                case (bus_req.addr[15:11])
                    5'b01100: begin  // 6000h to 67FFh
                        wr_cmd.valid = 1'b1;
                        wr_cmd.half  = 1'b0;
                    end
                    5'b01110: begin  // 7000h to 77FFh
                        wr_cmd.valid = 1'b1;
                        wr_cmd.half  = 1'b1;
                    end
                    default: wr_cmd.valid = 1'b0;  // Outside both windows
                endcase
                // Code 10h maps SRAM in when the cartridge has some
                wr_cmd.sram  = (bus_req.data == 8'h10) & sram_exists;
                wr_cmd.value = bus_req.data;
            end
        end
    end

endmodule

// ==== verilog/cart_bank_regs.sv ====
`timescale 1ns/1ns
`include "cart_defs.svh"

module cart_bank_regs (
    input  logic                          cpu_bus,
    input  logic                          arst_n,
    input  cart_mapper_pkg::mapper_id_t   id,
    input  cart_mapper_pkg::reg_wr_t      wr_cmd,
    output cart_mapper_pkg::bank_t        bank0,
    output cart_mapper_pkg::bank_t        bank1,
    output logic [1:0]                    sram_en
);

    // One register set per mapper instance
    cart_mapper_pkg::bank_t bank0_q [`CART_NUM_IDS];
    cart_mapper_pkg::bank_t bank1_q [`CART_NUM_IDS];
    logic [1:0]             sram_q  [`CART_NUM_IDS];  // Bit per window

    always_ff @(posedge cpu_bus or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CART_NUM_IDS; i++) begin
                bank0_q[i] <= '0;
                bank1_q[i] <= '0;
                sram_q[i]  <= 2'b00;
            end
        end else if (wr_cmd.valid) begin
            if (wr_cmd.sram) begin
                // Bank number stays, the window now points at SRAM
                sram_q[id][wr_cmd.half] <= 1'b1;
            end else begin
                sram_q[id][wr_cmd.half] <= 1'b0;  // Back to ROM
                if (wr_cmd.half) begin
                    bank1_q[id] <= wr_cmd.value;
                end else begin
                    bank0_q[id] <= wr_cmd.value;
                end
            end
        end
    end

    // Registers of the active instance only
    assign bank0   = bank0_q[id];
    assign bank1   = bank1_q[id];
    assign sram_en = sram_q[id];

endmodule

// ==== verilog/cart_addr_gen.sv ====
`timescale 1ns/1ns
`include "cart_defs.svh"

module cart_addr_gen (
    input  cart_bus_pkg::cpu_req_t        bus_req,
    input  cart_mapper_pkg::mapper_cfg_t  cfg,
    input  logic                          cs,
    input  logic                          rtype,
    input  cart_mapper_pkg::bank_t        bank0,
    input  cart_mapper_pkg::bank_t        bank1,
    input  logic [1:0]                    sram_en,
    output cart_bus_pkg::mem_out_t        mem
);

    localparam int PAGE_W     = 14;  // 16 KB bank window
    localparam int ROM_PAD_W  = `CART_MEM_ADDR_W - `CART_BANK_W - PAGE_W;
    localparam int SRAM8_PAD  = `CART_MEM_ADDR_W - 13;  // 8 KB SRAM
    localparam int SRAM2_PAD  = `CART_MEM_ADDR_W - 11;  // 2 KB SRAM

    cart_mapper_pkg::bank_t  bank_base;
    logic                    sel_sram;     // Window currently mapped to SRAM
    cart_bus_pkg::mem_addr_t rom_addr;
    cart_bus_pkg::mem_addr_t sram_addr;
    cart_bus_pkg::mem_addr_t rom_limit;
    logic                    rom_valid;
    logic                    sram_cs;

    // Upper window always uses bank1, lower one is fixed at 0Fh for R-Type
    assign bank_base = bus_req.addr[15] ? bank1 : (rtype ? 8'h0F : bank0);
    assign sel_sram  = sram_en[bus_req.addr[15]];

    assign rom_addr  = {{ROM_PAD_W{1'b0}}, bank_base, bus_req.addr[PAGE_W-1:0]};
    assign sram_addr = (cfg.sram_size > 16'd2) ?
                       {{SRAM8_PAD{1'b0}}, bus_req.addr[12:0]} :
                       {{SRAM2_PAD{1'b0}}, bus_req.addr[10:0]};  // Small SRAM mirrors

    // Reads past the end of the image are not forwarded
    assign rom_limit = {{(`CART_MEM_ADDR_W-`CART_ROM_SIZE_W){1'b0}}, cfg.rom_size};
    assign rom_valid = (rom_addr < rom_limit);

    assign sram_cs = cs & sel_sram;

    always_comb begin
        mem.sram_cs = sram_cs;
        mem.ram_cs  = cs & rom_valid & ~sel_sram & bus_req.rd;  // ROM is read only
        // SRAM is writable only through the 8000h window
        mem.rnw     = ~(sram_cs & bus_req.wr & bus_req.addr[15]);
        if (!cs) begin
            mem.addr = '1;  // Idle address
        end else if (sel_sram) begin
            mem.addr = sram_addr;
        end else begin
            mem.addr = rom_addr;
        end
    end

endmodule

// ==== verilog/cart_mapper_top.sv ====
`timescale 1ns/1ns

module cart_mapper_top (
    input  logic                          cpu_bus,
    input  logic                          arst_n,
    input  cart_bus_pkg::cpu_req_t        bus_req,
    input  cart_mapper_pkg::mapper_cfg_t  cfg,
    output cart_bus_pkg::mem_out_t        mem
);

    logic                      cs;       // Access belongs to the mapper
    logic                      rtype;
    cart_mapper_pkg::reg_wr_t  wr_cmd;   // Decoded register update
    cart_mapper_pkg::bank_t    bank0;
    cart_mapper_pkg::bank_t    bank1;
    logic [1:0]                sram_en;

    // Window and type decode
    cart_map_ctrl u_ctrl (
        .bus_req (bus_req),
        .cfg     (cfg),
        .cs      (cs),
        .rtype   (rtype),
        .wr_cmd  (wr_cmd)
    );

    // Per-instance bank state
    cart_bank_regs u_regs (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .id      (cfg.id),
        .wr_cmd  (wr_cmd),
        .bank0   (bank0),
        .bank1   (bank1),
        .sram_en (sram_en)
    );

    // Memory side request
    cart_addr_gen u_addr (
        .bus_req (bus_req),
        .cfg     (cfg),
        .cs      (cs),
        .rtype   (rtype),
        .bank0   (bank0),
        .bank1   (bank1),
        .sram_en (sram_en),
        .mem     (mem)
    );

endmodule

// ==== verif/cart_clk_gen.sv ====
`timescale 1ns/1ns

module cart_clk_gen #(
    parameter int PERIOD     = 20,  // ns
    parameter int RST_CYCLES = 8
) (
    output logic cpu_bus,
    output logic arst_n
);

    initial begin
        cpu_bus = 1'b0;
        forever #(PERIOD / 2) cpu_bus = ~cpu_bus;
    end

    initial begin
        arst_n = 1'b0;  // Reset active from time zero
        repeat (RST_CYCLES) @(posedge cpu_bus);
        @(negedge cpu_bus);
        arst_n = 1'b1;  // Released away from the active edge
    end

endmodule

// ==== verif/cart_checker.sv ====
`timescale 1ns/1ns

module cart_checker (
    input  logic                   cpu_bus,
    input  logic                   arst_n,
    input  cart_bus_pkg::mem_out_t mem,      // DUT response
    input  cart_bus_pkg::mem_out_t exp_mem,  // Expected row
    input  logic                   chk,      // Row carries a check
    output int                     errors,
    output int                     checks
);

    initial begin
        errors = 0;
        checks = 0;
    end

    // One field against its expected value, X counts as a mismatch
    task automatic compare_field(
        input string      name,
        input logic [26:0] got,
        input logic [26:0] want
    );
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, want);
        end
    endtask

    // Outputs are combinational, settled by the falling edge
    always @(negedge cpu_bus) begin
        if (arst_n && chk) begin
            checks++;
            compare_field("ram_cs", 27'(mem.ram_cs), 27'(exp_mem.ram_cs));
            compare_field("sram_cs", 27'(mem.sram_cs), 27'(exp_mem.sram_cs));
            compare_field("rnw", 27'(mem.rnw), 27'(exp_mem.rnw));
            compare_field("addr", mem.addr, exp_mem.addr);
        end
    end

endmodule

// ==== verif/cart_tb.sv ====
`timescale 1ns/1ns

module cart_tb;

    typedef struct packed {
        cart_mapper_pkg::mapper_cfg_t cfg;
        cart_bus_pkg::cpu_req_t       req;
        cart_bus_pkg::mem_out_t       exp;
        logic                         chk;  // Compare this row
    } row_t;

    logic                         cpu_bus;
    logic                         arst_n;
    cart_bus_pkg::cpu_req_t       bus_req;
    cart_mapper_pkg::mapper_cfg_t cfg;
    cart_bus_pkg::mem_out_t       mem;
    cart_bus_pkg::mem_out_t       exp_mem;
    logic                         chk;
    int                           errors;
    int                           checks;
    int                           cycles = 0;
    int                           limit = 0;  // Set once the table is built
    row_t                         tbl [$];

    cart_clk_gen u_clk (.cpu_bus(cpu_bus), .arst_n(arst_n));

    cart_mapper_top u_dut (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .bus_req (bus_req),
        .cfg     (cfg),
        .mem     (mem)
    );

    cart_checker u_chk (
        .cpu_bus (cpu_bus),
        .arst_n  (arst_n),
        .mem     (mem),
        .exp_mem (exp_mem),
        .chk     (chk),
        .errors  (errors),
        .checks  (checks)
    );

    function automatic cart_mapper_pkg::mapper_cfg_t make_cfg(
        input cart_mapper_pkg::mapper_typ_e typ,
        input cart_mapper_pkg::mapper_id_t  id,
        input logic [24:0]                  rom_size,
        input logic [15:0]                  sram_size
    );
        cart_mapper_pkg::mapper_cfg_t c;
        c.typ       = typ;
        c.id        = id;
        c.rom_size  = rom_size;
        c.sram_size = sram_size;
        return c;
    endfunction

    function automatic cart_bus_pkg::cpu_req_t make_req(
        input logic [15:0] addr,
        input logic [7:0]  data,
        input logic        wr
    );
        cart_bus_pkg::cpu_req_t r;
        r.addr = addr;
        r.data = data;
        r.rd   = ~wr;
        r.wr   = wr;
        r.mreq = 1'b1;
        return r;
    endfunction

    // ROM response, bank base followed by address bits 13..0
    function automatic cart_bus_pkg::mem_out_t rom_hit(
        input logic [7:0] bank, input logic [15:0] addr, input logic sel);
        cart_bus_pkg::mem_out_t m;
        m.ram_cs  = sel;
        m.sram_cs = 1'b0;
        m.rnw     = 1'b1;
        m.addr    = {bank, addr[13:0]};  // Zero extended to 27 bits
        return m;
    endfunction

    function automatic cart_bus_pkg::mem_out_t sram_hit(input logic [26:0] a, input logic rnw);
        cart_bus_pkg::mem_out_t m;
        m.ram_cs  = 1'b0;
        m.sram_cs = 1'b1;
        m.rnw     = rnw;
        m.addr    = a;
        return m;
    endfunction

    function automatic cart_bus_pkg::mem_out_t idle_out();
        cart_bus_pkg::mem_out_t m;
        m.ram_cs  = 1'b0;
        m.sram_cs = 1'b0;
        m.rnw     = 1'b1;
        m.addr    = '1;  // Nothing selected
        return m;
    endfunction

    task automatic add_row(input cart_mapper_pkg::mapper_cfg_t c, input cart_bus_pkg::cpu_req_t r,
                           input cart_bus_pkg::mem_out_t e, input logic check);
        row_t row;
        row.cfg = c;
        row.req = r;
        row.exp = e;
        row.chk = check;
        tbl.push_back(row);
    endtask

    task automatic add_read(input cart_mapper_pkg::mapper_cfg_t c, input logic [15:0] addr,
                            input cart_bus_pkg::mem_out_t e);
        add_row(c, make_req(addr, 8'h00, 1'b0), e, 1'b1);
    endtask

    task automatic add_write(input cart_mapper_pkg::mapper_cfg_t c, input logic [15:0] addr,
                             input logic [7:0] data);
        add_row(c, make_req(addr, data, 1'b1), idle_out(), 1'b0);  // Seen in the next row
    endtask

    task automatic build_table();
        cart_mapper_pkg::mapper_cfg_t a0, a0_s8, a0_s2, a1, r1, none;
        cart_bus_pkg::cpu_req_t       no_mreq;
        a0    = make_cfg(cart_mapper_pkg::MAPPER_ASCII16, 1'b0, 25'h001_8000, 16'd0);
        a0_s8 = make_cfg(cart_mapper_pkg::MAPPER_ASCII16, 1'b0, 25'h001_8000, 16'd8);
        a0_s2 = make_cfg(cart_mapper_pkg::MAPPER_ASCII16, 1'b0, 25'h001_8000, 16'd2);
        a1    = make_cfg(cart_mapper_pkg::MAPPER_ASCII16, 1'b1, 25'h080_0000, 16'd0);
        r1    = make_cfg(cart_mapper_pkg::MAPPER_RTYPE, 1'b1, 25'h080_0000, 16'd0);
        none  = make_cfg(cart_mapper_pkg::MAPPER_NONE, 1'b0, 25'h080_0000, 16'd0);
        no_mreq      = make_req(16'h4123, 8'h00, 1'b0);
        no_mreq.mreq = 1'b0;
        add_read(a0, 16'h4000, rom_hit(8'h00, 16'h4000, 1'b1));  // Banks clear after reset
        add_read(a0, 16'h0100, idle_out());
        add_row(a0, no_mreq, idle_out(), 1'b1);
        add_write(a0, 16'h6000, 8'h05);
        add_write(a0, 16'h7000, 8'h03);
        add_read(a0, 16'h4123, rom_hit(8'h05, 16'h4123, 1'b1));
        add_read(a0, 16'h8123, rom_hit(8'h03, 16'h8123, 1'b1));
        add_read(a0, 16'h7FFF, rom_hit(8'h05, 16'h7FFF, 1'b1));  // Last byte of the image
        add_write(a0, 16'h6000, 8'h06);
        add_read(a0, 16'h4000, rom_hit(8'h06, 16'h4000, 1'b0));  // Exactly at rom_size
        add_read(a0, 16'h4123, rom_hit(8'h06, 16'h4123, 1'b0));
        add_write(a0_s8, 16'h7000, 8'h10);  // 8 KB SRAM into the upper window
        add_row(a0_s8, make_req(16'h8010, 8'h5A, 1'b1), sram_hit(27'h10, 1'b0), 1'b1);
        add_read(a0_s8, 16'h8010, sram_hit(27'h10, 1'b1));
        add_read(a0_s8, 16'hA123, sram_hit(27'h123, 1'b1));
        add_read(a0_s8, 16'hC010, idle_out());  // SRAM enable alone selects nothing
        add_read(a0_s8, 16'h4123, rom_hit(8'h06, 16'h4123, 1'b0));  // Lower window stays ROM
        add_write(a0_s8, 16'h6000, 8'h10);
        add_row(a0_s8, make_req(16'h4010, 8'hA5, 1'b1), sram_hit(27'h10, 1'b1), 1'b1);
        add_write(a0_s8, 16'h6000, 8'h02);
        add_read(a0_s8, 16'h4123, rom_hit(8'h02, 16'h4123, 1'b1));
        add_write(a0, 16'h7000, 8'h10);  // No SRAM, so 10h is a bank
        add_read(a0, 16'h8123, rom_hit(8'h10, 16'h8123, 1'b0));
        add_write(a0_s2, 16'h7000, 8'h10);  // 2 KB SRAM mirrors on 11 bits
        add_read(a0_s2, 16'h8F23, sram_hit(27'h723, 1'b1));
        add_write(a0_s2, 16'h7000, 8'h03);
        add_read(a0_s2, 16'h8123, rom_hit(8'h03, 16'h8123, 1'b1));
        add_write(r1, 16'h7000, 8'h1A);  // Mask 17h
        add_read(r1, 16'h8123, rom_hit(8'h12, 16'h8123, 1'b1));
        add_write(r1, 16'h7800, 8'h0B);  // Mask 1Fh
        add_read(r1, 16'h8123, rom_hit(8'h0B, 16'h8123, 1'b1));
        add_read(r1, 16'h4123, rom_hit(8'h0F, 16'h4123, 1'b1));
        add_write(r1, 16'h6000, 8'h05);  // Ignored by R-Type
        add_read(r1, 16'h8123, rom_hit(8'h0B, 16'h8123, 1'b1));
        add_read(a1, 16'h4123, rom_hit(8'h00, 16'h4123, 1'b1));
        add_read(a1, 16'hBFFF, rom_hit(8'h0B, 16'hBFFF, 1'b1));
        add_read(a0, 16'h4123, rom_hit(8'h02, 16'h4123, 1'b1));  // Id 0 kept its banks
        add_read(a0, 16'h8123, rom_hit(8'h03, 16'h8123, 1'b1));
        add_row(a0, make_req(16'h8123, 8'h55, 1'b1), rom_hit(8'h03, 16'h8123, 1'b0), 1'b1);
        add_write(a1, 16'h6000, 8'h07);
        add_read(a0, 16'h4123, rom_hit(8'h02, 16'h4123, 1'b1));
        add_write(a0, 16'h6000, 8'h04);
        add_read(a1, 16'h4123, rom_hit(8'h07, 16'h4123, 1'b1));
        add_read(a0, 16'h4123, rom_hit(8'h04, 16'h4123, 1'b1));
        add_read(none, 16'h4123, idle_out());
        add_row(none, make_req(16'h6000, 8'h09, 1'b1), idle_out(), 1'b1);
        add_write(a0, 16'h6800, 8'h01);  // Past the end of the 6000h window
        add_read(a0, 16'h4123, rom_hit(8'h04, 16'h4123, 1'b1));
        add_read(a0, 16'hC000, idle_out());
    endtask

    initial begin
        bus_req <= '0;
        cfg     <= '0;
        exp_mem <= '0;
        chk     <= 1'b0;
        build_table();
        limit = 8 + 2 * tbl.size() + 20;
        wait (arst_n === 1'b1);
        foreach (tbl[i]) begin
            @(posedge cpu_bus);
            cfg     <= tbl[i].cfg;
            bus_req <= tbl[i].req;
            exp_mem <= tbl[i].exp;
            chk     <= tbl[i].chk;
        end
        @(posedge cpu_bus);  // Last row compared on the falling edge before this
        chk     <= 1'b0;
        bus_req <= '0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Run limit from reset length and table size
    always @(posedge cpu_bus) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the table did not complete", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/cart_bus_pkg.sv
verilog/cart_mapper_pkg.sv
verilog/cart_map_ctrl.sv
verilog/cart_bank_regs.sv
verilog/cart_addr_gen.sv
verilog/cart_mapper_top.sv
verif/cart_clk_gen.sv
verif/cart_checker.sv
verif/cart_tb.sv

// ==== Bender.yml ====
package:
  name: cart_mapper

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/cart_bus_pkg.sv
      - verilog/cart_mapper_pkg.sv
      - verilog/cart_map_ctrl.sv
      - verilog/cart_bank_regs.sv
      - verilog/cart_addr_gen.sv
      - verilog/cart_mapper_top.sv
  - target: test
    files:
      - verif/cart_clk_gen.sv
      - verif/cart_checker.sv
      - verif/cart_tb.sv
